/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory bank testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_mem_bank -f sim.f -o Vtb_mem_bank
./obj_dir/Vtb_mem_bank | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* sim.f */
+incdir+src
src/dram_pkg.sv
src/mem_req_pkg.sv
src/req_decode.sv
src/ras_cas_sequencer.sv
src/sip1m9.sv
src/read_parity_check.sv
src/mem_bank_top.sv
test/tb_mem_bank.sv

/* src/dram_pkg.sv */
`default_nettype none

`include "mem_defs.svh"

package dram_pkg;

  // Flat word address as the host sees it
  typedef logic [`WORD_ADDR_BITS-1:0] word_addr_t;

  // Row/column split of the same word
  // Row sits in the upper half
  typedef struct packed {
    logic [`ROW_BITS-1:0] row;  // Goes out under RAS
    logic [`COL_BITS-1:0] col;  // Goes out under CAS
  } row_col_t;

  // One address word read two ways
  typedef union packed {
    word_addr_t word;  // Host view
    row_col_t   rc;    // DRAM view
  } dram_addr_u;

endpackage

`default_nettype wire

/* src/mem_bank_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_bank_top (
  input  wire                        sysclk,
  input  wire                        arst_n,
  input  wire                        req,
  input  wire                        we,
  input  wire [`WORD_ADDR_BITS-1:0]  addr,
  input  wire [7:0]                  wdata,
  input  wire                        inj_par,
  output logic                       busy,
  output logic                       rd_valid,
  output logic [7:0]                 rdata,
  output logic                       par_err
);

  import mem_req_pkg::*;

  logic                  cmd_pend;
  logic                  cmd_go;
  mem_op_e               cmd_op;
  logic [`ROW_BITS-1:0]  cmd_row;
  logic [`COL_BITS-1:0]  cmd_col;
  logic [7:0]            cmd_wdata;
  logic                  cmd_inj;
  logic                  seq_busy;
  logic                  ras_n;       // DRAM strobes
  logic                  cas_n;
  logic                  w_n;
  logic [`COL_BITS-1:0]  dram_addr;
  logic [7:0]            d8;
  logic                  d9;
  logic [7:0]            q8;
  logic                  prd_n;
  logic                  sample;

  // Busy spans accept through precharge
  assign busy = cmd_pend || seq_busy;

  req_decode u_dec (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .inj_par   (inj_par),
    .seq_busy  (seq_busy),
    .cmd_pend  (cmd_pend),
    .cmd_go    (cmd_go),
    .cmd_op    (cmd_op),
    .cmd_row   (cmd_row),
    .cmd_col   (cmd_col),
    .cmd_wdata (cmd_wdata),
    .cmd_inj   (cmd_inj)
  );

  ras_cas_sequencer u_seq (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .cmd_go    (cmd_go),
    .cmd_op    (cmd_op),
    .cmd_row   (cmd_row),
    .cmd_col   (cmd_col),
    .cmd_wdata (cmd_wdata),
    .cmd_inj   (cmd_inj),
    .ras_n     (ras_n),
    .cas_n     (cas_n),
    .w_n       (w_n),
    .dram_addr (dram_addr),
    .d8        (d8),
    .d9        (d9),
    .sample    (sample),
    .busy      (seq_busy)
  );

  // q9 feeds only the parity output inside the SIP
  sip1m9 u_sip (
    .sysclk  (sysclk),
    .arst_n  (arst_n),
    .address (dram_addr),
    .ras_n   (ras_n),
    .cas_n   (cas_n),
    .w_n     (w_n),
    .d8      (d8),
    .d9      (d9),
    .q8      (q8),
    .q9      (),
    .prd_n   (prd_n)
  );

  read_parity_check u_chk (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .sample   (sample),
    .q8       (q8),
    .prd_n    (prd_n),
    .rd_valid (rd_valid),
    .rdata    (rdata),
    .par_err  (par_err)
  );

endmodule

`default_nettype wire

/* src/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Multiplexed DRAM address split
`define ROW_BITS        10  // Row half, latched on RAS fall
`define COL_BITS        10  // Column half, taken on CAS fall

// Flat host word address
`define WORD_ADDR_BITS  20

// Array depth actually built
// Upper address bits alias onto the same word
`define RAM_ADDR_BITS   16  // 64K words

// Strobe timing in sysclk cycles
`define T_RCD           2   // RAS low to CAS low
`define T_CAS           2   // CAS low width
`define T_RP            2   // Precharge with both strobes high

// Counter width for the strobe timing
`define SEQ_CNT_BITS    4

`endif

/* src/mem_req_pkg.sv */
`default_nettype none

package mem_req_pkg;

  // Host operation carried from decoder to sequencer
  // Encoding follows the host we bit
  typedef enum logic {
    OP_READ  = 1'b0,  // W_n stays high
    OP_WRITE = 1'b1   // W_n low under CAS
  } mem_op_e;

endpackage

`default_nettype wire

/* src/ras_cas_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module ras_cas_sequencer (
  input  wire                   sysclk,
  input  wire                   arst_n,
  input  wire                   cmd_go,
  input  wire mem_req_pkg::mem_op_e cmd_op,     // Held by decoder for the whole access
  input  wire [`ROW_BITS-1:0]   cmd_row,
  input  wire [`COL_BITS-1:0]   cmd_col,
  input  wire [7:0]             cmd_wdata,
  input  wire                   cmd_inj,
  output logic                  ras_n,
  output logic                  cas_n,
  output logic                  w_n,
  output logic [`COL_BITS-1:0]  dram_addr,  // Row first, then column
  output logic [7:0]            d8,
  output logic                  d9,         // Parity bit
  output logic                  sample,     // Read data good this cycle
  output logic                  busy
);

  import mem_req_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    RAS,        // First RAS-low cycle, row on the bus
    RCD,        // Rest of RAS to CAS delay
    CAS,        // CAS low, SIP accesses array
    PRECHARGE   // Both strobes high
  } seq_state_e;

  seq_state_e              state;
  logic [`SEQ_CNT_BITS-1:0] cnt;  // Cycles spent in current state

  // Strobes and FSM
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      cnt   <= '0;
      ras_n <= 1'b1;
      cas_n <= 1'b1;
      w_n   <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_go) begin
            state <= RAS;
            ras_n <= 1'b0;  // Row already valid for SIP at next edge
            cnt   <= '0;
          end
        end
        RAS: begin
          state <= RCD;
          cnt   <= '0;
        end
        RCD: begin
          if (cnt == `SEQ_CNT_BITS'(`T_RCD - 2)) begin
            state <= CAS;
            cas_n <= 1'b0;
            w_n   <= (cmd_op == OP_WRITE) ? 1'b0 : 1'b1;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        CAS: begin
          if (cnt == `SEQ_CNT_BITS'(`T_CAS - 1)) begin
            state <= PRECHARGE;
            ras_n <= 1'b1;  // Both strobes rise together
            cas_n <= 1'b1;
            w_n   <= 1'b1;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PRECHARGE: begin
          if (cnt == `SEQ_CNT_BITS'(`T_RP - 1)) begin
            state <= IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address mux and write data
  always_ff @(posedge sysclk) begin
    if (state == IDLE && cmd_go) begin
      dram_addr <= cmd_row;
      d8        <= cmd_wdata;
      d9        <= (^cmd_wdata) ^ cmd_inj;  // Even parity over 9 bits, flipped on inject
    end else if (state == RAS) begin
      dram_addr <= cmd_col;  // Column ahead of CAS fall
    end
  end

  // Last CAS-low cycle of a read
  assign sample = (state == CAS) && (cnt == `SEQ_CNT_BITS'(`T_CAS - 1)) &&
                  (cmd_op == OP_READ);
  assign busy   = (state != IDLE);

endmodule

`default_nettype wire

/* src/read_parity_check.sv */
`timescale 1ns/1ps
`default_nettype none

module read_parity_check (
  input  wire        sysclk,
  input  wire        arst_n,
  input  wire        sample,    // From sequencer, last CAS cycle
  input  wire [7:0]  q8,
  input  wire        prd_n,     // High means odd parity
  output logic       rd_valid,
  output logic [7:0] rdata,
  output logic       par_err
);

  // Valid pulse and error flag
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      par_err  <= 1'b0;
    end else begin
      rd_valid <= sample;  // One cycle per read
      if (sample) begin
        par_err <= prd_n;  // Held until next read
      end
    end
  end

  // Read data capture
  always_ff @(posedge sysclk) begin
    if (sample) begin
      rdata <= q8;
    end
  end

endmodule

`default_nettype wire

/* src/req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module req_decode (
  input  wire                        sysclk,
  input  wire                        arst_n,
  input  wire                        req,        // One-cycle host pulse
  input  wire                        we,
  input  wire [`WORD_ADDR_BITS-1:0]  addr,
  input  wire [7:0]                  wdata,
  input  wire                        inj_par,    // Poison parity of this write
  input  wire                        seq_busy,
  output logic                       cmd_pend,   // Accepted, not yet handed over
  output logic                       cmd_go,
  output mem_req_pkg::mem_op_e       cmd_op,
  output logic [`ROW_BITS-1:0]       cmd_row,
  output logic [`COL_BITS-1:0]       cmd_col,
  output logic [7:0]                 cmd_wdata,
  output logic                       cmd_inj
);

  import dram_pkg::*;
  import mem_req_pkg::*;

  dram_addr_u addr_q;  // Held until next accepted req
  logic       accept;

  // Requests during an access are dropped
  assign accept = req && !cmd_pend && !seq_busy;

  // Pending flag covers the gap until the sequencer goes busy
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_pend <= 1'b0;
      cmd_go   <= 1'b0;
    end else begin
      cmd_go <= cmd_pend && !cmd_go;  // Single pulse, edge after accept
      if (accept) begin
        cmd_pend <= 1'b1;
      end else if (cmd_go) begin
        cmd_pend <= 1'b0;  // Sequencer takes over busy from here
      end
    end
  end

  // Request fields
  always_ff @(posedge sysclk) begin
    if (accept) begin
      addr_q.word <= addr;
      cmd_op      <= we ? OP_WRITE : OP_READ;
      cmd_wdata   <= wdata;
      cmd_inj     <= inj_par;
    end
  end

  // Row and column straight from the split view
  assign cmd_row = addr_q.rc.row;
  assign cmd_col = addr_q.rc.col;

endmodule

`default_nettype wire

/* src/sip1m9.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module sip1m9 (
  input  wire                  sysclk,
  input  wire                  arst_n,
  input  wire [`COL_BITS-1:0]  address,  // Multiplexed row/column
  input  wire                  ras_n,
  input  wire                  cas_n,
  input  wire                  w_n,      // Low = write
  input  wire [7:0]            d8,
  input  wire                  d9,
  output logic [7:0]           q8,
  output logic                 q9,
  output logic                 prd_n     // High on odd parity
);

  logic [7:0] mem8 [0:(1 << `RAM_ADDR_BITS)-1];  // Data bits
  logic       mem9 [0:(1 << `RAM_ADDR_BITS)-1];  // Parity bit

  logic                             ras_q;  // Strobe history
  logic                             cas_q;
  logic [`ROW_BITS-1:0]             row_q;
  logic [7:0]                       q8_r;
  logic                             q9_r;
  logic                             ras_fall;
  logic                             cas_fall;
  logic                             rd_en;
  logic [`ROW_BITS+`COL_BITS-1:0]   full_addr;
  logic [`RAM_ADDR_BITS-1:0]        ram_idx;

  // Power-up contents are zero, which is good parity
  initial begin
    for (int i = 0; i < (1 << `RAM_ADDR_BITS); i++) begin
      mem8[i] = 8'h00;
      mem9[i] = 1'b0;
    end
  end

  // Edge detect in sysclk domain
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      ras_q <= 1'b1;
      cas_q <= 1'b1;
    end else begin
      ras_q <= ras_n;
      cas_q <= cas_n;
    end
  end

  assign ras_fall  = ras_q && !ras_n;
  assign cas_fall  = cas_q && !cas_n;
  assign full_addr = {row_q, address};
  assign ram_idx   = full_addr[`RAM_ADDR_BITS-1:0];  // High bits alias

  // Row latch and array access
  always_ff @(posedge sysclk) begin
    if (ras_fall) begin
      row_q <= address;
    end
    if (cas_fall && !ras_n) begin
      if (w_n) begin
        q8_r <= mem8[ram_idx];
        q9_r <= mem9[ram_idx];
      end else begin
        mem8[ram_idx] <= d8;
        mem9[ram_idx] <= d9;
      end
    end
  end

  // Outputs only while CAS low on a read
  assign rd_en = !cas_n && w_n;
  assign q8    = rd_en ? q8_r : 8'h00;
  assign q9    = rd_en ? q9_r : 1'b0;
  assign prd_n = rd_en ? ^{q8_r, q9_r} : 1'b1;

endmodule

`default_nettype wire

/* test/tb_mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_bank;

  localparam int N_REQS     = 400;
  localparam int MAX_CYCLES = N_REQS * 12 + 100;  // 9-cycle access plus idle gap

  logic                        sysclk;
  logic                        arst_n;
  logic                        req;
  logic                        we;
  logic [`WORD_ADDR_BITS-1:0]  addr;
  logic [7:0]                  wdata;
  logic                        inj_par;
  logic                        busy;
  logic                        rd_valid;
  logic [7:0]                  rdata;
  logic                        par_err;

  logic [31:0]                 rng;
  logic [`RAM_ADDR_BITS-1:0]   pool [16];  // Hot addresses so reads hit written words
  logic [8:0]                  model_mem [logic [`RAM_ADDR_BITS-1:0]];  // {poisoned, data}
  int                          cycle_cnt   = 0;
  int                          data_errs   = 0;
  int                          par_errs    = 0;
  int                          timing_errs = 0;
  int                          n_reads     = 0;
  int                          n_drops     = 0;

  mem_bank_top u_dut (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .inj_par  (inj_par),
    .busy     (busy),
    .rd_valid (rd_valid),
    .rdata    (rdata),
    .par_err  (par_err)
  );

  initial begin
    sysclk = 1'b0;
    forever #5 sysclk = ~sysclk;  // 100 MHz
  end

  // Watchdog
  always @(posedge sysclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: data %0d, parity %0d, timing %0d", data_errs, par_errs, timing_errs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One host access from edge 0 to edge 8 checked cycle by cycle
  task automatic do_access(
    input logic                       is_wr,
    input logic [`WORD_ADDR_BITS-1:0] a,
    input logic [7:0]                 d,
    input logic                       inj
  );
    logic [`RAM_ADDR_BITS-1:0]  key;
    logic [8:0]                 entry;
    logic [`WORD_ADDR_BITS-1:0] drop_addr;
    logic                       drop_we;
    logic                       exp_busy;
    logic                       exp_vld;
    int                         drop_at;
    key   = a[`RAM_ADDR_BITS-1:0];  // Upper bits alias
    entry = 9'h000;                 // Unwritten word reads zero with good parity
    if (model_mem.exists(key) != 0) begin
      entry = model_mem[key];
    end
    rng       = xorshift32(rng);
    drop_at   = (rng[2:0] == 3'd0) ? int'(rng[5:3]) % 7 + 1 : 0;  // Edge of a stray req
    drop_addr = {rng[11:8], pool[rng[15:12]]};
    drop_we   = rng[16];
    req     = 1'b1;
    we      = is_wr;
    addr    = a;
    wdata   = d;
    inj_par = inj;
    @(posedge sysclk);  // Edge 0
    #1;
    for (int n = 0; n <= 8; n++) begin
      if (n > 0) begin
        @(posedge sysclk);
        #1;
      end
      exp_busy = (n < 8);               // Low again after edge 8
      exp_vld  = (n == 6) && !is_wr;    // Read latency 6
      if (busy !== exp_busy) begin
        $display("Fail busy at edge %0d: got 0x%0h, expected 0x%0h", n, busy, exp_busy);
        timing_errs++;
      end
      if (rd_valid !== exp_vld) begin
        $display("Fail rd_valid at edge %0d: got 0x%0h, expected 0x%0h", n, rd_valid, exp_vld);
        timing_errs++;
      end
      if (exp_vld) begin
        if (rdata !== entry[7:0]) begin
          $display("Fail rdata at addr 0x%05h: got 0x%02h, expected 0x%02h",
                   a, rdata, entry[7:0]);
          data_errs++;
        end
        if (par_err !== entry[8]) begin
          $display("Fail par_err at addr 0x%05h: got 0x%0h, expected 0x%0h",
                   a, par_err, entry[8]);
          par_errs++;
        end
      end
      req = (drop_at != 0) && (n == drop_at - 1);  // Stray req while busy
      if (req) begin
        we      = drop_we;
        addr    = drop_addr;
        wdata   = ~d;
        inj_par = 1'b0;
        n_drops++;
      end
    end
    if (is_wr) begin
      model_mem[key] = {inj, d};  // Clean write clears poison
    end else begin
      n_reads++;
    end
  endtask

  initial begin
    logic [`WORD_ADDR_BITS-1:0] a;
    logic [`RAM_ADDR_BITS-1:0]  a_low;
    logic                       is_wr;
    logic                       inj;
    int                         gap;
    arst_n  = 1'b0;
    req     = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = 8'h00;
    inj_par = 1'b0;
    rng     = 32'd11801;
    for (int i = 0; i < 16; i++) begin
      rng     = xorshift32(rng);
      pool[i] = rng[15:0];
    end
    repeat (4) @(posedge sysclk);
    #1;
    arst_n = 1'b1;
    // Quiet until the first req
    repeat (3) begin
      if (busy !== 1'b0 || rd_valid !== 1'b0) begin
        $display("Fail busy/rd_valid after reset: got 0x%0h/0x%0h, expected 0x0/0x0",
                 busy, rd_valid);
        timing_errs++;
      end
      @(posedge sysclk);
      #1;
    end
    for (int k = 0; k < N_REQS; k++) begin
      rng = xorshift32(rng);
      if (rng[1:0] == 2'b00) begin
        a_low = rng[31:16];  // Anywhere and mostly never written
      end else begin
        a_low = pool[rng[5:2]];
      end
      a     = {rng[9:6], a_low};  // Random alias bits on top
      rng   = xorshift32(rng);
      is_wr = rng[0];
      inj   = is_wr && (rng[3:1] == 3'd0);  // Poison about 1 write in 8
      gap   = int'(rng[5:4]) % 3;
      repeat (gap) begin
        @(posedge sysclk);
        #1;
        if (rd_valid !== 1'b0) begin
          $display("Fail rd_valid between accesses: got 0x%0h, expected 0x0", rd_valid);
          timing_errs++;
        end
      end
      while (busy !== 1'b0) begin
        @(posedge sysclk);
        #1;
      end
      do_access(is_wr, a, rng[15:8], inj);
    end
    $display("Reads %0d, dropped reqs %0d, errors: data %0d, parity %0d, timing %0d",
             n_reads, n_drops, data_errs, par_errs, timing_errs);
    if (data_errs + par_errs + timing_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
